// ==== hw/dm_pkg.sv ====
//==================================================
// data mover types, command and status layouts,
// request struct and controller state encoding
//==================================================
package dm_pkg;

    localparam int btt_w  = 23;                 // bytes-to-transfer field
    localparam int addr_w = 32;                 // start address
    localparam int tag_w  = 4;                  // command / status tag

    typedef enum logic {
        dir_mm2s = 1'b0,                        // memory read
        dir_s2mm = 1'b1                         // memory write
    } dm_dir_e;

    // 60-bit request from the host side
    typedef struct packed {
        dm_dir_e                   dir;
        logic [addr_w-1:0]         addr;
        logic [btt_w-1:0]          btt;
        logic [tag_w-1:0]          tag;
    } dm_req_t;

    // 72-bit command word, msb first
    typedef struct packed {
        logic [3:0]                rsvd;        // bits 71:68, zero
        logic [tag_w-1:0]          tag;         // bits 67:64
        logic [addr_w-1:0]         saddr;       // bits 63:32
        logic                      drr;         // realign request, bit 31
        logic                      eof;         // end of frame, bit 30
        logic [5:0]                dsa;         // dre alignment, bits 29:24
        logic                      burst_type;  // incr burst, bit 23
        logic [btt_w-1:0]          btt;         // bits 22:0
    } dm_cmd_t;

    // 8-bit status returned by the data mover
    typedef struct packed {
        logic                      okay;        // bit 7
        logic                      slverr;      // bit 6
        logic                      decerr;      // bit 5
        logic                      interr;      // bit 4
        logic [tag_w-1:0]          tag;         // bits 3:0
    } dm_sts_t;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait_sts
    } dm_state_e;

endpackage

// ==== hw/axis_pkg.sv ====
//==================================================
// stream beat structs, 32-bit memory read side
// and 64-bit udp payload side
//==================================================
package axis_pkg;

    // 37 bits, one beat from the mm2s read stream
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  keep;                      // byte enables
        logic        last;                      // end of packet
    } axis32_t;

    // 73 bits, one beat toward the udp tx payload
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;                      // byte enables
        logic        last;                      // end of packet
    } axis64_t;

endpackage

// ==== hw/dm_cmd_ctrl.sv ====
//==================================================
// data mover command controller
// request -> 72-bit command on mm2s or s2mm,
// status capture and completion report
//==================================================
module dm_cmd_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,       // one-cycle strobe
    input  dm_pkg::dm_req_t             req,
    input  logic                        mm2s_cmd_ready,
    input  logic                        s2mm_cmd_ready,
    input  logic                        mm2s_sts_valid,
    input  dm_pkg::dm_sts_t             mm2s_sts,
    input  logic                        s2mm_sts_valid,
    input  dm_pkg::dm_sts_t             s2mm_sts,
    output logic                        mm2s_cmd_valid,
    output logic                        s2mm_cmd_valid,
    output dm_pkg::dm_cmd_t             cmd,
    output logic                        mm2s_sts_ready,
    output logic                        s2mm_sts_ready,
    output logic                        busy,
    output logic                        done,            // one-cycle pulse
    output logic [dm_pkg::tag_w-1:0]    done_tag,
    output logic                        done_err
);

    dm_pkg::dm_state_e  state_q;
    dm_pkg::dm_req_t    req_q;                           // request in flight
    dm_pkg::dm_sts_t    sts_sel;                         // status of active dir
    logic               is_mm2s;
    logic               req_take;
    logic               zero_len;
    logic               cmd_hs;
    logic               sts_hs;
    logic               sts_bad;

    //==================================================
    // handshakes and steering
    //==================================================
    assign is_mm2s  = (req_q.dir == dm_pkg::dir_mm2s);
    assign req_take = req_valid && (state_q == dm_pkg::st_idle); // dropped while busy
    assign zero_len = (req.btt == '0);

    assign busy           = (state_q != dm_pkg::st_idle);
    assign mm2s_cmd_valid = (state_q == dm_pkg::st_issue) &&  is_mm2s;
    assign s2mm_cmd_valid = (state_q == dm_pkg::st_issue) && !is_mm2s;
    assign mm2s_sts_ready = (state_q == dm_pkg::st_wait_sts) &&  is_mm2s;
    assign s2mm_sts_ready = (state_q == dm_pkg::st_wait_sts) && !is_mm2s;

    assign cmd_hs = (mm2s_cmd_valid && mm2s_cmd_ready) || (s2mm_cmd_valid && s2mm_cmd_ready);
    assign sts_hs = (mm2s_sts_valid && mm2s_sts_ready) || (s2mm_sts_valid && s2mm_sts_ready);

    assign sts_sel = is_mm2s ? mm2s_sts : s2mm_sts;
    assign sts_bad = !sts_sel.okay || sts_sel.interr || sts_sel.decerr || sts_sel.slverr
                     || (sts_sel.tag != req_q.tag);      // tag echo mismatch

    // command word, fixed fields per data mover layout
    always_comb begin
        cmd            = '0;
        cmd.btt        = req_q.btt;
        cmd.burst_type = 1'b1;                           // incr
        cmd.dsa        = '0;                             // no dre realign
        cmd.eof        = 1'b1;
        cmd.drr        = 1'b0;
        cmd.saddr      = req_q.addr;
        cmd.tag        = req_q.tag;
        cmd.rsvd       = '0;
    end

    //==================================================
    // state machine
    //==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= dm_pkg::st_idle;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;                                // pulse default
            case (state_q)
                dm_pkg::st_idle: begin
                    if (req_take) begin
                        if (zero_len) begin
                            done <= 1'b1;                // reject, no command
                        end else begin
                            state_q <= dm_pkg::st_issue;
                        end
                    end
                end
                dm_pkg::st_issue: begin
                    if (cmd_hs) state_q <= dm_pkg::st_wait_sts;
                end
                dm_pkg::st_wait_sts: begin
                    if (sts_hs) begin
                        done    <= 1'b1;
                        state_q <= dm_pkg::st_idle;
                    end
                end
                default: state_q <= dm_pkg::st_idle;
            endcase
        end
    end

    // request latch and completion payload
    always_ff @(posedge clk) begin
        if (req_take) begin
            req_q    <= req;
            done_tag <= req.tag;
            done_err <= 1'b1;                            // only seen if zero length
        end
        if ((state_q == dm_pkg::st_wait_sts) && sts_hs) begin
            done_tag <= req_q.tag;
            done_err <= sts_bad;
        end
    end

endmodule

// ==== hw/axis_upsizer.sv ====
//==================================================
// 32-bit to 64-bit stream upsizer
// low half first, early close on last
//==================================================
module axis_upsizer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              s_axis_valid,
    input  axis_pkg::axis32_t s_axis,
    output logic              s_axis_ready,
    output logic              m_axis_valid,
    input  logic              m_axis_ready,
    output axis_pkg::axis64_t m_axis
);

    logic [31:0] half_data;                     // first beat, low lane
    logic [3:0]  half_keep;
    logic        lane_q;                        // 1 = low half filled
    logic        in_hs;

    assign s_axis_ready = !m_axis_valid;        // single output slot
    assign in_hs        = s_axis_valid && s_axis_ready;

    // control flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_q       <= 1'b0;
            m_axis_valid <= 1'b0;
        end else begin
            if (m_axis_valid && m_axis_ready) m_axis_valid <= 1'b0;
            if (in_hs) begin
                if (lane_q || s_axis.last) begin
                    m_axis_valid <= 1'b1;       // pair complete or closed early
                    lane_q       <= 1'b0;
                end else begin
                    lane_q <= 1'b1;
                end
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (in_hs) begin
            if (lane_q) begin
                m_axis.data <= {s_axis.data, half_data};
                m_axis.keep <= {s_axis.keep, half_keep};
                m_axis.last <= s_axis.last;
            end else if (s_axis.last) begin
                m_axis.data <= {32'h0, s_axis.data};
                m_axis.keep <= {4'h0, s_axis.keep};  // high lane empty
                m_axis.last <= 1'b1;
            end else begin
                half_data <= s_axis.data;
                half_keep <= s_axis.keep;
            end
        end
    end

endmodule

// ==== hw/axis_fifo.sv ====
//==================================================
// single-clock 64-bit stream fifo
// circular buffer plus registered output stage
//==================================================
module axis_fifo #(
    parameter int FIFO_DEPTH = 16                     // power of two, >= 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              s_axis_valid,
    input  axis_pkg::axis64_t s_axis,
    output logic              s_axis_ready,
    output logic              m_axis_valid,
    input  logic              m_axis_ready,
    output axis_pkg::axis64_t m_axis
);

    localparam int addr_bits = $clog2(FIFO_DEPTH);

    axis_pkg::axis64_t    mem [FIFO_DEPTH];
    logic [addr_bits:0]   wr_ptr;                     // extra msb for wrap
    logic [addr_bits:0]   rd_ptr;
    logic                 empty;
    logic                 full;
    logic                 wr_en;
    logic                 rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_bits] != rd_ptr[addr_bits]) &&
                   (wr_ptr[addr_bits-1:0] == rd_ptr[addr_bits-1:0]);

    assign s_axis_ready = !full;
    assign wr_en = s_axis_valid && !full;
    assign rd_en = !empty && (!m_axis_valid || m_axis_ready); // refill output reg

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            m_axis_valid <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            if (rd_en)             m_axis_valid <= 1'b1;
            else if (m_axis_ready) m_axis_valid <= 1'b0;   // drained
        end
    end

    // storage and output data
    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr[addr_bits-1:0]] <= s_axis;
        if (rd_en) m_axis <= mem[rd_ptr[addr_bits-1:0]];
    end

endmodule

// ==== hw/data_mover_top.sv ====
//==================================================
// data mover top, command controller and
// mm2s stream path (upsizer + fifo)
//==================================================
module data_mover_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // request / completion
    input  logic                        req_valid,
    input  dm_pkg::dm_req_t             req,
    output logic                        busy,
    output logic                        done,
    output logic [dm_pkg::tag_w-1:0]    done_tag,
    output logic                        done_err,
    // command streams
    output logic                        mm2s_cmd_valid,
    input  logic                        mm2s_cmd_ready,
    output logic                        s2mm_cmd_valid,
    input  logic                        s2mm_cmd_ready,
    output dm_pkg::dm_cmd_t             cmd,
    // status streams
    input  logic                        mm2s_sts_valid,
    output logic                        mm2s_sts_ready,
    input  dm_pkg::dm_sts_t             mm2s_sts,
    input  logic                        s2mm_sts_valid,
    output logic                        s2mm_sts_ready,
    input  dm_pkg::dm_sts_t             s2mm_sts,
    // mm2s data in, udp payload out
    input  logic                        s_axis_valid,
    input  axis_pkg::axis32_t           s_axis,
    output logic                        s_axis_ready,
    output logic                        m_axis_valid,
    output axis_pkg::axis64_t           m_axis,
    input  logic                        m_axis_ready
);

    logic              up_valid;                // upsizer -> fifo
    logic              up_ready;
    axis_pkg::axis64_t up_beat;

    dm_cmd_ctrl i_cmd_ctrl (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req(req),
        .mm2s_cmd_ready(mm2s_cmd_ready), .s2mm_cmd_ready(s2mm_cmd_ready),
        .mm2s_sts_valid(mm2s_sts_valid), .mm2s_sts(mm2s_sts),
        .s2mm_sts_valid(s2mm_sts_valid), .s2mm_sts(s2mm_sts),
        .mm2s_cmd_valid(mm2s_cmd_valid), .s2mm_cmd_valid(s2mm_cmd_valid), .cmd(cmd),
        .mm2s_sts_ready(mm2s_sts_ready), .s2mm_sts_ready(s2mm_sts_ready),
        .busy(busy), .done(done), .done_tag(done_tag), .done_err(done_err)
    );

    axis_upsizer i_upsizer (
        .clk(clk), .rst_n(rst_n),
        .s_axis_valid(s_axis_valid), .s_axis(s_axis), .s_axis_ready(s_axis_ready),
        .m_axis_valid(up_valid), .m_axis_ready(up_ready), .m_axis(up_beat)
    );

    axis_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_fifo (
        .clk(clk), .rst_n(rst_n),
        .s_axis_valid(up_valid), .s_axis(up_beat), .s_axis_ready(up_ready),
        .m_axis_valid(m_axis_valid), .m_axis_ready(m_axis_ready), .m_axis(m_axis)
    );

endmodule

// ==== verification/tb_data_mover_top.sv ====
//==================================================
// testbench for the data mover top level
// stimulus file reader, command/status responder,
// stream driver and collector, watchdog
//==================================================
module tb_data_mover_top;

    localparam int fifo_depth      = 16;
    localparam int cycles_per_line = 200;            // watchdog budget per line

    logic clk, rst_n, req_valid, busy, done, done_err;
    logic [3:0] done_tag;
    dm_pkg::dm_req_t   req;
    dm_pkg::dm_cmd_t   cmd;
    dm_pkg::dm_sts_t   mm2s_sts, s2mm_sts;
    logic mm2s_cmd_valid, mm2s_cmd_ready, s2mm_cmd_valid, s2mm_cmd_ready;
    logic mm2s_sts_valid, mm2s_sts_ready, s2mm_sts_valid, s2mm_sts_ready;
    logic s_axis_valid, s_axis_ready, m_axis_valid, m_axis_ready;
    axis_pkg::axis32_t s_axis;
    axis_pkg::axis64_t m_axis;

    int          seed = 32'hd302;
    int          n_lines, tests_run, total_errs, test_errs;
    int          mm2s_cnt, s2mm_cnt, done_cnt;   // handshake counters
    logic [71:0] cmd_seen;
    logic [3:0]  tag_seen;
    logic        err_seen;
    string       test_name;
    string       lines[$];

    data_mover_top #(.FIFO_DEPTH(fifo_depth)) i_dut (.*);

    always #50 clk = ~clk;

    // monitor at negedge where all dut outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (mm2s_cmd_valid && mm2s_cmd_ready) begin
                mm2s_cnt++;
                cmd_seen = cmd;
            end
            if (s2mm_cmd_valid && s2mm_cmd_ready) begin
                s2mm_cnt++;
                cmd_seen = cmd;
            end
            if (done) begin
                done_cnt++;
                tag_seen = done_tag;
                err_seen = done_err;
            end
        end
    end

    task automatic check_value(input string what, input logic [72:0] exp, input logic [72:0] act);
        if (exp !== act) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("test %s: %s", test_name, msg);
        test_errs++;
        total_errs++;
    endtask

    function automatic int rand_delay();
        return int'($unsigned($random(seed)) % 4);   // 0..3 cycles
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;                                         // drive point after the edge
    endtask

    //==================================================
    // request test with a responder for the data mover
    //==================================================
    task automatic run_request(input string ln);
        string       nm, kd;
        logic        dir, exp_err, overlap;
        logic [31:0] addr;
        logic [22:0] btt;
        logic [3:0]  tag;
        logic [7:0]  sts;
        logic [71:0] exp_cmd;
        int          rc, m0, s0, d0, n;
        rc = $sscanf(ln, "%s %s %h %h %h %h %h %h %h", nm, kd, dir, addr, btt, tag, sts,
                     exp_err, overlap);
        if (rc != 9) begin
            report_failure("malformed request line in stimulus file");
            return;
        end
        exp_cmd = {4'h0, tag, addr, 1'b0, 1'b1, 6'h0, 1'b1, btt};  // msb down to btt at bit 0
        m0 = mm2s_cnt;
        s0 = s2mm_cnt;
        d0 = done_cnt;
        mm2s_cmd_ready = (btt == '0) || dir;         // idle direction takes any stray command
        s2mm_cmd_ready = (btt == '0) || !dir;
        req.dir   = dm_pkg::dm_dir_e'(dir);
        req.addr  = addr;
        req.btt   = btt;
        req.tag   = tag;
        req_valid = 1'b1;
        next_cycle();
        req_valid = 1'b0;
        if (btt == '0) begin
            check_value("busy", 0, busy);            // zero length never goes busy
        end else begin
            n = 0;
            while (!(mm2s_cmd_valid || s2mm_cmd_valid) && n < 20) begin
                next_cycle();
                n++;
            end
            if (n == 20) report_failure("no command valid after the request");
            check_value("busy", 1, busy);
            if (overlap) begin
                req.tag   = tag ^ 4'h1;              // second strobe while busy
                req_valid = 1'b1;
                next_cycle();
                req_valid = 1'b0;
            end
            repeat (rand_delay()) next_cycle();
            if (dir) s2mm_cmd_ready = 1'b1;
            else     mm2s_cmd_ready = 1'b1;
            next_cycle();                            // ready stays high to catch a repeat command
            repeat (rand_delay()) next_cycle();
            check_value("sts_ready", 1, dir ? s2mm_sts_ready : mm2s_sts_ready);
            check_value("other_sts_ready", 0, dir ? mm2s_sts_ready : s2mm_sts_ready);
            if (dir) begin
                s2mm_sts       = sts;
                s2mm_sts_valid = 1'b1;
            end else begin
                mm2s_sts       = sts;
                mm2s_sts_valid = 1'b1;
            end
            next_cycle();
            mm2s_sts_valid = 1'b0;
            s2mm_sts_valid = 1'b0;
        end
        n = 0;
        while (done_cnt == d0 && n < 20) begin
            next_cycle();
            n++;
        end
        if (done_cnt == d0) begin
            report_failure("done never pulsed");
        end else begin
            check_value("done_tag", tag, tag_seen);
            check_value("done_err", exp_err, err_seen);
        end
        repeat (4) next_cycle();                     // window for stray commands or done
        mm2s_cmd_ready = 1'b0;
        s2mm_cmd_ready = 1'b0;
        check_value("mm2s_cmds", (!dir && btt != 0) ? 1 : 0, mm2s_cnt - m0);
        check_value("s2mm_cmds", (dir && btt != 0) ? 1 : 0, s2mm_cnt - s0);
        check_value("done_count", 1, done_cnt - d0);
        if (btt != '0) check_value("cmd", exp_cmd, cmd_seen);
    endtask

    //==================================================
    // stream test with 32-bit beats in and 64-bit out
    //==================================================
    task automatic run_stream(input string ln);
        string             nm, kd;
        logic [31:0]       first;
        logic [3:0]        last_keep;
        logic              saw_full, taken;
        int                rc, count, stall, got, cyc, i, k;
        axis_pkg::axis32_t beat, lo, hi;
        axis_pkg::axis32_t in_q[$];
        axis_pkg::axis64_t exp_beat;
        axis_pkg::axis64_t exp_q[$];
        rc = $sscanf(ln, "%s %s %h %h %d %d", nm, kd, first, last_keep, count, stall);
        if (rc != 6 || count < 1) begin
            report_failure("malformed stream line in stimulus file");
            return;
        end
        for (i = 0; i < count; i++) begin
            beat.data = first + i;
            beat.keep = (i == count - 1) ? last_keep : 4'hf;
            beat.last = (i == count - 1);
            in_q.push_back(beat);
        end
        i = 0;
        while (i < count) begin                      // low lane first and early close on last
            lo = in_q[i];
            if (lo.last) begin
                exp_beat = '{data: {32'h0, lo.data}, keep: {4'h0, lo.keep}, last: 1'b1};
                i += 1;
            end else begin
                hi = in_q[i+1];
                exp_beat = '{data: {hi.data, lo.data}, keep: {hi.keep, lo.keep}, last: hi.last};
                i += 2;
            end
            exp_q.push_back(exp_beat);
        end
        saw_full = 1'b0;
        got      = 0;
        cyc      = 0;
        fork
            begin
                for (k = 0; k < count; k++) begin
                    s_axis_valid = 1'b1;
                    s_axis       = in_q[k];
                    taken        = 1'b0;
                    while (!taken) begin
                        taken = s_axis_ready;        // ready is a flop and holds to the next edge
                        next_cycle();
                    end
                end
                s_axis_valid = 1'b0;
            end
            begin
                while (got < exp_q.size() && cyc < count * 20) begin
                    if (stall != 0) m_axis_ready = (cyc >= 60) && (($random(seed) & 1) != 0);
                    else            m_axis_ready = 1'b1;
                    if (!i_dut.up_ready) saw_full = 1'b1;   // fifo full seen
                    if (m_axis_ready && m_axis_valid) begin
                        check_value($sformatf("beat%0d", got), exp_q[got], m_axis);
                        got++;
                    end
                    next_cycle();
                    cyc++;
                end
            end
        join
        if (got < exp_q.size()) report_failure("stream output stopped before the last beat");
        m_axis_ready = 1'b1;
        repeat (3) next_cycle();
        check_value("extra_beat", 0, m_axis_valid);
        if (stall != 0) check_value("fifo_full", exp_q.size() > fifo_depth + 2, saw_full);
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs == 0) $display("test %s ok", test_name);
        else                $display("test %s failed with %0d errors", test_name, test_errs);
        test_errs = 0;
    endtask

    //==================================================
    // main sequence and watchdog
    //==================================================
    initial begin
        string ln, nm, kd;
        int    fd, rc;
        clk = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        mm2s_cmd_ready = 1'b0;
        s2mm_cmd_ready = 1'b0;
        mm2s_sts_valid = 1'b0;
        s2mm_sts_valid = 1'b0;
        mm2s_sts = '0;
        s2mm_sts = '0;
        s_axis_valid = 1'b0;
        s_axis = '0;
        m_axis_ready = 1'b0;
        repeat (4) @(posedge clk);
        #10 rst_n = 1'b1;
        test_name = "reset";
        check_value("idle_outputs", 0, {busy, done, mm2s_cmd_valid, s2mm_cmd_valid,
                                        mm2s_sts_ready, s2mm_sts_ready, m_axis_valid});
        finish_test();
        fd = $fopen("verification/tb_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verification/tb_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                ln = "";
                rc = $fgets(ln, fd);
                if (rc > 0 && ln.len() > 1 && ln.getc(0) != 8'h23) begin
                    lines.push_back(ln);             // comment lines start with #
                end
            end
            $fclose(fd);
        end
        n_lines = lines.size();
        foreach (lines[j]) begin
            rc = $sscanf(lines[j], "%s %s", nm, kd);
            test_name = nm;
            if (kd == "R")      run_request(lines[j]);
            else if (kd == "S") run_stream(lines[j]);
            else                report_failure("unknown line kind in stimulus file");
            finish_test();
        end
        $display("tests %0d, errors %0d", tests_run, total_errs);
        if (total_errs == 0 && n_lines > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        wait (n_lines != 0);
        repeat (n_lines * cycles_per_line) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish",
                 n_lines * cycles_per_line);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== verification/tb_stimulus.txt ====
# R lines (hex): name R dir addr btt tag status expected_err overlap_strobe
# S lines: name S first_data(hex) last_keep(hex) beat_count stall_mode
mm2s_basic    R 0 80001000 000400 3 83 0 0
s2mm_basic    R 1 40002000 001000 5 85 0 0
s2mm_max_btt  R 1 00000040 7fffff a 8a 0 0
mm2s_max_addr R 0 fffffffc 7fffff f 8f 0 0
s2mm_tag0     R 1 00000000 000001 0 80 0 0
mm2s_slverr   R 0 10000000 000100 6 c6 1 0
s2mm_decerr   R 1 20000000 000100 7 a7 1 0
mm2s_interr   R 0 30000000 000010 8 98 1 0
s2mm_no_okay  R 1 50000000 000080 9 09 1 0
mm2s_bad_tag  R 0 60000000 000020 2 8c 1 0
mm2s_zero_len R 0 70000000 000000 b 8b 1 0
s2mm_zero_len R 1 70000040 000000 c 8c 1 0
mm2s_busy     R 0 90000000 000200 d 8d 0 1
s2mm_busy     R 1 a0000000 000200 e 8e 0 1
stream_odd    S 11110000 3 5 0
stream_even   S 22220000 f 8 0
stream_single S 33330000 1 1 0
stream_pair   S 44440000 c 2 0
stream_fill   S a0000000 f 41 1
stream_stall  S b0000000 7 13 1

// ==== compile.f ====
hw/dm_pkg.sv
hw/axis_pkg.sv
hw/dm_cmd_ctrl.sv
hw/axis_upsizer.sv
hw/axis_fifo.sv
hw/data_mover_top.sv
verification/tb_data_mover_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the data mover testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_data_mover_top -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
